/* rtl/rv_pkg.sv */
package rv_pkg;

  localparam int xlen       = 32;
  localparam int mem_words  = 256;
  localparam int mem_addr_w = 8;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Encodings
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  typedef enum logic [6:0] {
    op_r   = 7'b0110011,
    op_i   = 7'b0010011,
    op_lw  = 7'b0000011,
    op_sw  = 7'b0100011,
    op_beq = 7'b1100011,
    op_jal = 7'b1101111
  } opcode_t;

  typedef enum logic [2:0] {
    alu_add, alu_sub, alu_and, alu_or, alu_slt
  } alu_op_t;

  typedef enum logic [3:0] {
    s_fetch, s_decode, s_mem_adr, s_mem_read, s_mem_wb, s_mem_write,
    s_execute_r, s_execute_i, s_alu_wb, s_branch, s_jump
  } fsm_state_t;

  typedef enum logic [1:0] {src_a_zero, src_a_old_pc, src_a_rs1} src_a_t;
  typedef enum logic [1:0] {src_b_rs2, src_b_imm, src_b_four} src_b_t;
  typedef enum logic [1:0] {res_alu_out, res_data, res_alu_result} result_src_t;
  typedef enum logic [1:0] {cls_add, cls_sub, cls_funct} alu_class_t; // Forced or decoded

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Instruction formats
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    opcode_t    opcode;
  } r_fmt_t;

  typedef struct packed {
    logic [11:0] imm;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    opcode_t     opcode;
  } i_fmt_t;

  typedef struct packed {
    logic [6:0] imm_hi;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] imm_lo;
    opcode_t    opcode;
  } s_fmt_t;

  typedef struct packed {
    logic       imm12;
    logic [5:0] imm10_5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [3:0] imm4_1;
    logic       imm11;
    opcode_t    opcode;
  } b_fmt_t;

  typedef struct packed {
    logic       imm20;
    logic [9:0] imm10_1;
    logic       imm11;
    logic [7:0] imm19_12;
    logic [4:0] rd;
    opcode_t    opcode;
  } j_fmt_t;

  typedef union packed {
    r_fmt_t r_fmt;
    i_fmt_t i_fmt;
    s_fmt_t s_fmt;
    b_fmt_t b_fmt;
    j_fmt_t j_fmt;
  } instr_t;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Control word and ports
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  typedef struct packed {
    logic        adr_src;   // Data address instead of pc
    logic        ir_write;
    logic        reg_write;
    logic        mem_write;
    logic        pc_update;
    src_a_t      src_a;
    src_b_t      src_b;
    result_src_t result_src;
    alu_class_t  alu_op_class;
  } ctrl_t;

  typedef struct packed {
    logic                  valid;
    logic [mem_addr_w-1:0] addr;
    logic [xlen-1:0]       data;
  } prog_load_t;

  typedef struct packed {
    logic                  valid;
    logic [mem_addr_w-1:0] addr;
    logic [xlen-1:0]       data;
  } store_evt_t;

endpackage

/* rtl/control_fsm.sv */
module control_fsm
  ( input  logic            clk
  , input  logic            reset
  , input  rv_pkg::opcode_t opcode
  , input  logic            zero
  , output rv_pkg::ctrl_t   ctrl
  );

  rv_pkg::fsm_state_t state;
  rv_pkg::fsm_state_t state_next;

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= rv_pkg::s_fetch;
    end else begin
      state <= state_next;
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // State graph
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_comb begin
    state_next = rv_pkg::s_fetch;
    case (state)
      rv_pkg::s_fetch: state_next = rv_pkg::s_decode;
      rv_pkg::s_decode: begin
        case (opcode)
          rv_pkg::op_lw,
          rv_pkg::op_sw:  state_next = rv_pkg::s_mem_adr;
          rv_pkg::op_r:   state_next = rv_pkg::s_execute_r;
          rv_pkg::op_i:   state_next = rv_pkg::s_execute_i;
          rv_pkg::op_beq: state_next = rv_pkg::s_branch;
          rv_pkg::op_jal: state_next = rv_pkg::s_jump;
          default:        state_next = rv_pkg::s_fetch; // Unsupported, skip it
        endcase
      end
      rv_pkg::s_mem_adr: begin
        state_next = (opcode == rv_pkg::op_lw) ? rv_pkg::s_mem_read : rv_pkg::s_mem_write;
      end
      rv_pkg::s_mem_read:  state_next = rv_pkg::s_mem_wb;
      rv_pkg::s_execute_r: state_next = rv_pkg::s_alu_wb;
      rv_pkg::s_execute_i: state_next = rv_pkg::s_alu_wb;
      rv_pkg::s_jump:      state_next = rv_pkg::s_alu_wb; // Link written next
      default:             state_next = rv_pkg::s_fetch;
    endcase
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Control word per state
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_comb begin
    ctrl = '0;
    case (state)
      rv_pkg::s_fetch: begin
        ctrl.ir_write  = 1'b1;
        ctrl.pc_update = 1'b1; // pc + 4
      end
      rv_pkg::s_decode: begin
        ctrl.src_a = rv_pkg::src_a_old_pc; // Branch target into alu_out
        ctrl.src_b = rv_pkg::src_b_imm;
      end
      rv_pkg::s_mem_adr: begin
        ctrl.src_a = rv_pkg::src_a_rs1;
        ctrl.src_b = rv_pkg::src_b_imm;
      end
      rv_pkg::s_mem_read: begin
        ctrl.adr_src    = 1'b1;
        ctrl.result_src = rv_pkg::res_alu_out;
      end
      rv_pkg::s_mem_wb: begin
        ctrl.result_src = rv_pkg::res_data;
        ctrl.reg_write  = 1'b1;
      end
      rv_pkg::s_mem_write: begin
        ctrl.adr_src    = 1'b1;
        ctrl.result_src = rv_pkg::res_alu_out;
        ctrl.mem_write  = 1'b1;
      end
      rv_pkg::s_execute_r: begin
        ctrl.src_a        = rv_pkg::src_a_rs1;
        ctrl.src_b        = rv_pkg::src_b_rs2;
        ctrl.alu_op_class = rv_pkg::cls_funct;
      end
      rv_pkg::s_execute_i: begin
        ctrl.src_a        = rv_pkg::src_a_rs1;
        ctrl.src_b        = rv_pkg::src_b_imm;
        ctrl.alu_op_class = rv_pkg::cls_funct;
      end
      rv_pkg::s_alu_wb: begin
        ctrl.result_src = rv_pkg::res_alu_out;
        ctrl.reg_write  = 1'b1;
      end
      rv_pkg::s_branch: begin
        ctrl.src_a        = rv_pkg::src_a_rs1;
        ctrl.src_b        = rv_pkg::src_b_rs2;
        ctrl.alu_op_class = rv_pkg::cls_sub;
        ctrl.result_src   = rv_pkg::res_alu_out;
        ctrl.pc_update    = zero; // Taken only on equal
      end
      rv_pkg::s_jump: begin
        ctrl.src_a      = rv_pkg::src_a_old_pc; // Link value old_pc + 4
        ctrl.src_b      = rv_pkg::src_b_four;
        ctrl.result_src = rv_pkg::res_alu_out;
        ctrl.pc_update  = 1'b1;
      end
      default: ctrl = '0;
    endcase
  end

endmodule

/* rtl/fetch.sv */
module fetch
  ( input  logic                    clk
  , input  logic                    reset
  , input  rv_pkg::ctrl_t           ctrl
  , input  logic [rv_pkg::xlen-1:0] rdata
  , input  logic [rv_pkg::xlen-1:0] result_data
  , output logic [rv_pkg::xlen-1:0] pc
  , output logic [rv_pkg::xlen-1:0] old_pc
  , output rv_pkg::instr_t          instr
  );

  logic [rv_pkg::xlen-1:0] next_pc;

  // Sequential step during fetch, otherwise the result path
  assign next_pc = ctrl.ir_write ? pc + 32'd4 : result_data;

  always_ff @(posedge clk) begin
    if (reset) begin
      pc <= '0;
    end else if (ctrl.pc_update) begin
      pc <= next_pc;
    end
  end

  always_ff @(posedge clk) begin
    if (ctrl.ir_write) begin
      old_pc <= pc; // Address of the instruction now in flight
      instr  <= rdata;
    end
  end

endmodule

/* rtl/instr_decode.sv */
module instr_decode
  ( input  logic                    clk
  , input  logic                    reset
  , input  rv_pkg::ctrl_t           ctrl
  , input  rv_pkg::instr_t          instr
  , input  logic [rv_pkg::xlen-1:0] result_data
  , output logic [rv_pkg::xlen-1:0] rs1
  , output logic [rv_pkg::xlen-1:0] rs2
  , output logic [rv_pkg::xlen-1:0] imm_ext
  , output rv_pkg::alu_op_t         alu_op
  );

  logic [rv_pkg::xlen-1:0] regs [32];

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Register file
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (ctrl.reg_write && instr.r_fmt.rd != 5'd0) begin // x0 stays zero
      regs[instr.r_fmt.rd] <= result_data;
    end
  end

  assign rs1 = regs[instr.r_fmt.rs1];
  assign rs2 = regs[instr.r_fmt.rs2];

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Immediates
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_comb begin
    case (instr.r_fmt.opcode)
      rv_pkg::op_sw: begin
        imm_ext = {{20{instr.s_fmt.imm_hi[6]}}, instr.s_fmt.imm_hi, instr.s_fmt.imm_lo};
      end
      rv_pkg::op_beq: begin
        imm_ext = {{19{instr.b_fmt.imm12}}, instr.b_fmt.imm12, instr.b_fmt.imm11,
                   instr.b_fmt.imm10_5, instr.b_fmt.imm4_1, 1'b0};
      end
      rv_pkg::op_jal: begin
        imm_ext = {{11{instr.j_fmt.imm20}}, instr.j_fmt.imm20, instr.j_fmt.imm19_12,
                   instr.j_fmt.imm11, instr.j_fmt.imm10_1, 1'b0};
      end
      default: imm_ext = {{20{instr.i_fmt.imm[11]}}, instr.i_fmt.imm}; // I-type and lw
    endcase
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // ALU control
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_comb begin
    case (ctrl.alu_op_class)
      rv_pkg::cls_add: alu_op = rv_pkg::alu_add;
      rv_pkg::cls_sub: alu_op = rv_pkg::alu_sub;
      default: begin
        case (instr.r_fmt.funct3)
          3'b000: begin
            // funct7 is part of the immediate for addi
            alu_op = (instr.r_fmt.opcode == rv_pkg::op_r && instr.r_fmt.funct7[5])
                   ? rv_pkg::alu_sub : rv_pkg::alu_add;
          end
          3'b010:  alu_op = rv_pkg::alu_slt;
          3'b110:  alu_op = rv_pkg::alu_or;
          3'b111:  alu_op = rv_pkg::alu_and;
          default: alu_op = rv_pkg::alu_add;
        endcase
      end
    endcase
  end

endmodule

/* rtl/execute.sv */
module execute
  ( input  logic                    clk
  , input  rv_pkg::ctrl_t           ctrl
  , input  rv_pkg::alu_op_t         alu_op
  , input  logic [rv_pkg::xlen-1:0] rs1
  , input  logic [rv_pkg::xlen-1:0] rs2
  , input  logic [rv_pkg::xlen-1:0] imm_ext
  , input  logic [rv_pkg::xlen-1:0] old_pc
  , output logic [rv_pkg::xlen-1:0] alu_result
  , output logic [rv_pkg::xlen-1:0] alu_out
  , output logic                    zero
  );

  logic [rv_pkg::xlen-1:0] src_a;
  logic [rv_pkg::xlen-1:0] src_b;

  always_comb begin
    case (ctrl.src_a)
      rv_pkg::src_a_old_pc: src_a = old_pc;
      rv_pkg::src_a_rs1:    src_a = rs1;
      default:              src_a = '0;
    endcase
  end

  always_comb begin
    case (ctrl.src_b)
      rv_pkg::src_b_imm:  src_b = imm_ext;
      rv_pkg::src_b_four: src_b = 32'd4;
      default:            src_b = rs2;
    endcase
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // ALU
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_comb begin
    case (alu_op)
      rv_pkg::alu_sub: alu_result = src_a - src_b;
      rv_pkg::alu_and: alu_result = src_a & src_b;
      rv_pkg::alu_or:  alu_result = src_a | src_b;
      rv_pkg::alu_slt: alu_result = {31'd0, $signed(src_a) < $signed(src_b)};
      default:         alu_result = src_a + src_b;
    endcase
  end

  assign zero = (alu_result == '0); // Equality test for beq

  always_ff @(posedge clk) begin
    alu_out <= alu_result;
  end

endmodule

/* rtl/result.sv */
module result
  ( input  logic                    clk
  , input  rv_pkg::ctrl_t           ctrl
  , input  logic [rv_pkg::xlen-1:0] alu_result
  , input  logic [rv_pkg::xlen-1:0] alu_out
  , input  logic [rv_pkg::xlen-1:0] rdata
  , output logic [rv_pkg::xlen-1:0] result_data
  );

  logic [rv_pkg::xlen-1:0] data;

  always_ff @(posedge clk) begin
    data <= rdata; // Load data, used one state later
  end

  // Feeds writeback, the pc and the data address
  always_comb begin
    case (ctrl.result_src)
      rv_pkg::res_data:       result_data = data;
      rv_pkg::res_alu_result: result_data = alu_result;
      default:                result_data = alu_out;
    endcase
  end

endmodule

/* rtl/memory.sv */
module memory
  ( input  logic                    clk
  , input  logic                    reset
  , input  rv_pkg::prog_load_t      prog
  , input  rv_pkg::ctrl_t           ctrl
  , input  logic [rv_pkg::xlen-1:0] addr
  , input  logic [rv_pkg::xlen-1:0] wdata
  , output logic [rv_pkg::xlen-1:0] rdata
  , output rv_pkg::store_evt_t      store
  );

  logic [rv_pkg::xlen-1:0]       mem [rv_pkg::mem_words];
  logic [rv_pkg::mem_addr_w-1:0] word_addr;

  assign word_addr = addr[rv_pkg::mem_addr_w+1:2]; // Byte address to word index

  always_ff @(posedge clk) begin
    if (reset) begin
      if (prog.valid) begin
        mem[prog.addr] <= prog.data; // Program load only under reset
      end
    end else if (ctrl.mem_write) begin
      mem[word_addr] <= wdata;
    end
  end

  assign rdata = mem[word_addr];

  // Report every sw in the cycle it writes
  assign store.valid = ctrl.mem_write;
  assign store.addr  = word_addr;
  assign store.data  = wdata;

endmodule

/* rtl/core_top.sv */
module core_top
  ( input  logic               clk
  , input  logic               reset
  , input  rv_pkg::prog_load_t prog
  , output rv_pkg::store_evt_t store
  );

  rv_pkg::ctrl_t           ctrl;
  rv_pkg::instr_t          instr;
  rv_pkg::alu_op_t         alu_op;
  logic [rv_pkg::xlen-1:0] pc;
  logic [rv_pkg::xlen-1:0] old_pc;
  logic [rv_pkg::xlen-1:0] rs1;
  logic [rv_pkg::xlen-1:0] rs2;
  logic [rv_pkg::xlen-1:0] imm_ext;
  logic [rv_pkg::xlen-1:0] alu_result;
  logic [rv_pkg::xlen-1:0] alu_out;
  logic [rv_pkg::xlen-1:0] result_data;
  logic [rv_pkg::xlen-1:0] rdata;
  logic                    zero;

  wire [rv_pkg::xlen-1:0] mem_addr = ctrl.adr_src ? result_data : pc;

  control_fsm control_fsm
    ( .clk    ( clk                  )
    , .reset  ( reset                )
    , .opcode ( instr.r_fmt.opcode   )
    , .zero   ( zero                 )
    , .ctrl   ( ctrl                 )
    );

  fetch fetch
    ( .clk         ( clk         )
    , .reset       ( reset       )
    , .ctrl        ( ctrl        )
    , .rdata       ( rdata       )
    , .result_data ( result_data )
    , .pc          ( pc          )
    , .old_pc      ( old_pc      )
    , .instr       ( instr       )
    );

  instr_decode instr_decode
    ( .clk         ( clk         )
    , .reset       ( reset       )
    , .ctrl        ( ctrl        )
    , .instr       ( instr       )
    , .result_data ( result_data )
    , .rs1         ( rs1         )
    , .rs2         ( rs2         )
    , .imm_ext     ( imm_ext     )
    , .alu_op      ( alu_op      )
    );

  execute execute
    ( .clk        ( clk        )
    , .ctrl       ( ctrl       )
    , .alu_op     ( alu_op     )
    , .rs1        ( rs1        )
    , .rs2        ( rs2        )
    , .imm_ext    ( imm_ext    )
    , .old_pc     ( old_pc     )
    , .alu_result ( alu_result )
    , .alu_out    ( alu_out    )
    , .zero       ( zero       )
    );

  result result
    ( .clk         ( clk         )
    , .ctrl        ( ctrl        )
    , .alu_result  ( alu_result  )
    , .alu_out     ( alu_out     )
    , .rdata       ( rdata       )
    , .result_data ( result_data )
    );

  memory memory
    ( .clk   ( clk      )
    , .reset ( reset    )
    , .prog  ( prog     )
    , .ctrl  ( ctrl     )
    , .addr  ( mem_addr )
    , .wdata ( rs2      )
    , .rdata ( rdata    )
    , .store ( store    )
    );

endmodule

/* verification/core_tb.sv */
module core_tb;

  timeunit 1ns;
  timeprecision 1ps;

  typedef struct packed {
    logic [2:0]  test_id;
    logic [7:0]  addr;
    logic [31:0] data;
  } store_exp_t;

  localparam int run_limit = 2000;

  logic               clk;
  logic               reset;
  rv_pkg::prog_load_t prog;
  rv_pkg::store_evt_t store;

  logic [31:0] prog_mem [256];
  logic        loaded [256];
  int          test_of [256];
  int          prog_len;
  int          store_slot;
  store_exp_t  exp_mem [64];
  int          exp_count;
  int          store_idx;
  store_exp_t  exp_cur;
  logic        exp_left;

  core_top dut0 (.clk(clk), .reset(reset), .prog(prog), .store(store));

  always #4 clk = ~clk;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Instruction encoding
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  function automatic logic [31:0] encode_r(logic [6:0] f7, logic [4:0] rs2, logic [4:0] rs1,
                                           logic [2:0] f3, logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, 7'b0110011};
  endfunction

  function automatic logic [31:0] encode_i(logic [11:0] imm, logic [4:0] rs1, logic [2:0] f3,
                                           logic [4:0] rd, logic [6:0] op);
    return {imm, rs1, f3, rd, op};
  endfunction

  function automatic logic [31:0] encode_s(logic [11:0] imm, logic [4:0] rs2, logic [4:0] rs1);
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
  endfunction

  function automatic logic [31:0] encode_b(logic [12:0] imm, logic [4:0] rs2, logic [4:0] rs1);
    return {imm[12], imm[10:5], rs2, rs1, 3'b000, imm[4:1], imm[11], 7'b1100011};
  endfunction

  function automatic logic [31:0] encode_j(logic [20:0] imm, logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
  endfunction

  function automatic string test_name(logic [2:0] id);
    case (id)
      3'd1:    return "r_type_alu";
      3'd2:    return "i_type_imm";
      3'd3:    return "store_load";
      3'd4:    return "branch_eq";
      3'd5:    return "jump_link";
      3'd6:    return "zero_reg";
      default: return "unknown";
    endcase
  endfunction

  task automatic place(input int idx, input logic [31:0] w, input int test_id);
    prog_mem[idx] = w;
    loaded[idx]   = 1'b1;
    test_of[idx]  = test_id;
  endtask

  task automatic emit(input logic [31:0] w, input int test_id);
    place(prog_len, w, test_id);
    prog_len++;
  endtask

  task automatic emit_store(input logic [4:0] rs2, input int test_id);
    logic [11:0] slot_addr;
    slot_addr = 12'h280 + 12'(store_slot * 4); // Each store gets its own word
    emit(encode_s(slot_addr, rs2, 5'd0), test_id);
    store_slot++;
  endtask

  task automatic build_program();
    logic [11:0] imm;
    for (int i = 0; i < 256; i++) begin
      loaded[i]  = 1'b0;
      test_of[i] = 0;
    end
    prog_len   = 0;
    store_slot = 0;
    place(200, $urandom(), 0); // Random operands at 0x320 and 0x324
    place(201, $urandom(), 0);
    emit(encode_i(12'h320, 5'd0, 3'b010, 5'd1, rv_pkg::op_lw), 1);
    emit(encode_i(12'h324, 5'd0, 3'b010, 5'd2, rv_pkg::op_lw), 1);
    emit(encode_r(7'h00, 5'd2, 5'd1, 3'b000, 5'd3), 1); // add
    emit_store(5'd3, 1);
    emit(encode_r(7'h20, 5'd2, 5'd1, 3'b000, 5'd3), 1); // sub
    emit_store(5'd3, 1);
    emit(encode_r(7'h00, 5'd2, 5'd1, 3'b111, 5'd3), 1); // and
    emit_store(5'd3, 1);
    emit(encode_r(7'h00, 5'd2, 5'd1, 3'b110, 5'd3), 1); // or
    emit_store(5'd3, 1);
    emit(encode_r(7'h00, 5'd2, 5'd1, 3'b010, 5'd3), 1); // slt both ways
    emit_store(5'd3, 1);
    emit(encode_r(7'h00, 5'd1, 5'd2, 3'b010, 5'd3), 1);
    emit_store(5'd3, 1);
    imm = 12'($urandom()) | 12'h800; // Negative immediate
    emit(encode_i(imm, 5'd1, 3'b000, 5'd4, rv_pkg::op_i), 2);
    emit_store(5'd4, 2);
    emit(encode_i(12'($urandom()), 5'd1, 3'b111, 5'd4, rv_pkg::op_i), 2);
    emit_store(5'd4, 2);
    emit(encode_i(12'($urandom()), 5'd1, 3'b110, 5'd4, rv_pkg::op_i), 2);
    emit_store(5'd4, 2);
    emit(encode_i(12'($urandom()), 5'd1, 3'b010, 5'd4, rv_pkg::op_i), 2);
    emit_store(5'd4, 2);
    emit(encode_i(12'hfff, 5'd0, 3'b000, 5'd5, rv_pkg::op_i), 2);
    emit(encode_i(12'h000, 5'd5, 3'b010, 5'd4, rv_pkg::op_i), 2); // -1 < 0
    emit_store(5'd4, 2);
    emit(encode_s(12'h300, 5'd1, 5'd0), 3); // Scratch word at 0x300
    emit(encode_i(12'h300, 5'd0, 3'b010, 5'd6, rv_pkg::op_lw), 3);
    emit_store(5'd6, 3);
    emit(encode_i(12'd5, 5'd0, 3'b000, 5'd7, rv_pkg::op_i), 4);
    emit(encode_i(12'd5, 5'd0, 3'b000, 5'd8, rv_pkg::op_i), 4);
    emit(encode_b(13'd8, 5'd8, 5'd7), 4); // Taken, skips the store
    emit_store(5'd7, 4);
    emit(encode_i(12'd1, 5'd8, 3'b000, 5'd8, rv_pkg::op_i), 4);
    emit(encode_b(13'd8, 5'd8, 5'd7), 4); // Not taken
    emit_store(5'd8, 4);
    emit(encode_j(21'd8, 5'd9), 5);
    emit_store(5'd0, 5);
    emit_store(5'd9, 5);
    emit(encode_i(12'd123, 5'd0, 3'b000, 5'd0, rv_pkg::op_i), 6);
    emit(encode_i(12'h320, 5'd0, 3'b010, 5'd0, rv_pkg::op_lw), 6);
    emit(encode_r(7'h00, 5'd2, 5'd1, 3'b000, 5'd0), 6);
    emit_store(5'd0, 6);
    emit(encode_j(21'd0, 5'd0), 0); // Park in a self loop
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Reference model
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  task automatic run_model();
    logic [31:0] r [32];
    logic [31:0] m [256];
    logic [31:0] pc;
    logic [31:0] w;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] res;
    logic [31:0] ea;
    logic [31:0] imm_i;
    logic        wr;
    logic        done;
    for (int i = 0; i < 32; i++) r[i] = '0;
    for (int i = 0; i < 256; i++) m[i] = prog_mem[i];
    pc        = '0;
    exp_count = 0;
    done      = 1'b0;
    for (int step = 0; step < 1000 && !done; step++) begin
      w     = m[pc[9:2]];
      a     = r[w[19:15]];
      b     = r[w[24:20]];
      imm_i = {{20{w[31]}}, w[31:20]};
      wr    = 1'b0;
      res   = '0;
      case (w[6:0])
        rv_pkg::op_r, rv_pkg::op_i: begin
          if (w[6:0] == rv_pkg::op_i) b = imm_i;
          case (w[14:12])
            3'b000:  res = (w[6:0] == rv_pkg::op_r && w[30]) ? a - b : a + b;
            3'b010:  res = {31'd0, $signed(a) < $signed(b)};
            3'b110:  res = a | b;
            default: res = a & b;
          endcase
          wr = 1'b1;
        end
        rv_pkg::op_lw: begin
          ea  = a + imm_i;
          res = m[ea[9:2]];
          wr  = 1'b1;
        end
        rv_pkg::op_sw: begin
          ea = a + {{20{w[31]}}, w[31:25], w[11:7]};
          m[ea[9:2]] = b;
          exp_mem[exp_count] = '{test_id: 3'(test_of[pc[9:2]]), addr: ea[9:2], data: b};
          exp_count++;
        end
        rv_pkg::op_jal: begin
          res = pc + 4;
          wr  = 1'b1;
          if (w == encode_j(21'd0, 5'd0)) done = 1'b1;
        end
        default: ;
      endcase
      if (wr && w[11:7] != 5'd0) r[w[11:7]] = res;
      if (w[6:0] == rv_pkg::op_beq && a == b) begin
        pc = pc + {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
      end else if (w[6:0] == rv_pkg::op_jal) begin
        pc = pc + {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
      end else begin
        pc = pc + 4;
      end
    end
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Store checks
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_ff @(posedge clk) begin
    if (reset) begin
      store_idx <= 0;
    end else if (store.valid) begin
      store_idx <= store_idx + 1;
    end
  end

  assign exp_left = store_idx < exp_count;
  assign exp_cur  = exp_mem[store_idx[5:0]];

  store_expected: assert property (@(posedge clk) disable iff (reset)
    store.valid |-> exp_left)
  else begin
    $display("Store to word %0d arrived after all %0d expected stores",
             $sampled(store.addr), exp_count);
    $display("Test failed");
    $fatal(1);
  end

  store_matches: assert property (@(posedge clk) disable iff (reset)
    store.valid && exp_left |-> store.addr == exp_cur.addr && store.data == exp_cur.data)
  else begin
    $display("MISMATCH %s expected word %0d data %h actual word %0d data %h",
             test_name($sampled(exp_cur.test_id)), $sampled(exp_cur.addr),
             $sampled(exp_cur.data), $sampled(store.addr), $sampled(store.data));
    $display("Test failed");
    $fatal(1);
  end

  initial begin
    int cycles;
    clk   = 1'b0;
    reset = 1'b1;
    prog  = '0;
    void'($urandom(60879));
    build_program();
    run_model();
    for (int i = 0; i < 256; i++) begin
      if (loaded[i]) begin
        @(posedge clk);
        prog <= '{valid: 1'b1, addr: i[7:0], data: prog_mem[i]};
      end
    end
    @(posedge clk);
    prog <= '0;
    repeat (10) @(posedge clk); // Reset tail after the load
    reset <= 1'b0;
    cycles = 0;
    while (store_idx < exp_count && cycles < run_limit) begin
      @(posedge clk);
      cycles++;
    end
    if (store_idx >= exp_count) begin
      repeat (40) @(posedge clk); // Self loop, no more stores
      $display("Test completed successfully");
      $finish;
    end else begin
      $display("Timeout after %0d cycles with %0d of %0d stores seen",
               cycles, store_idx, exp_count);
      $display("Test failed");
      $fatal(1);
    end
  end

endmodule

/* src.f */
rtl/rv_pkg.sv
rtl/control_fsm.sv
rtl/fetch.sv
rtl/instr_decode.sv
rtl/execute.sv
rtl/result.sv
rtl/memory.sv
rtl/core_top.sv
verification/core_tb.sv

/* Bender.yml */
package:
  name: rv_multicycle

sources:
  - rtl/rv_pkg.sv
  - rtl/control_fsm.sv
  - rtl/fetch.sv
  - rtl/instr_decode.sv
  - rtl/execute.sv
  - rtl/result.sv
  - rtl/memory.sv
  - rtl/core_top.sv
  - target: test
    files:
      - verification/core_tb.sv
